// ==== cu_config.svh ====
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// Instruction word, opcode in the high nibble and sub-code in the low one
`define CU_INSTR_W 8

// Datapath register file, one write enable per register
`define CU_REG_N 16

// Registers with a dedicated incrementer
`define CU_INC_W 6

// Registers with a synchronous clear
`define CU_RST_W 5

// Compare pairs M, K and N
`define CU_CMP_W 3

`endif

// ==== cu_pkg.sv ====
`include "cu_config.svh"

package cu_pkg;

    // High nibble of the instruction
    typedef enum logic [3:0] {
        OP_NOOP  = 4'd0,
        OP_JMP   = 4'd1,
        OP_COPY  = 4'd2,
        OP_LOAD  = 4'd3,
        OP_STORE = 4'd4,
        OP_RESET = 4'd6,
        OP_MOVE  = 4'd7,
        OP_SET   = 4'd8,
        OP_MUL   = 4'd9,
        OP_ADD   = 4'd10,
        OP_INC   = 4'd11
    } opcode_e;

    // Sub-codes, per opcode group
    localparam logic [3:0] SUB_JMP_M    = 4'd0;
    localparam logic [3:0] SUB_JMP_K    = 4'd1;
    localparam logic [3:0] SUB_JMP_N    = 4'd2;
    localparam logic [3:0] SUB_COPY_M1  = 4'd0;
    localparam logic [3:0] SUB_COPY_K1  = 4'd1;
    localparam logic [3:0] SUB_COPY_N1  = 4'd2;
    localparam logic [3:0] SUB_LOAD_C1  = 4'd0;
    localparam logic [3:0] SUB_LOAD_C2  = 4'd1;
    localparam logic [3:0] SUB_RST_ALL  = 4'd0;
    localparam logic [3:0] SUB_RST_N2   = 4'd1;
    localparam logic [3:0] SUB_RST_K2   = 4'd2;
    localparam logic [3:0] SUB_MOVE_RP  = 4'd0;
    localparam logic [3:0] SUB_MOVE_RT  = 4'd1;
    localparam logic [3:0] SUB_MOVE_C1  = 4'd2;
    localparam logic [3:0] SUB_SET_C1   = 4'd0;
    localparam logic [3:0] SUB_SET_DR   = 4'd1;
    localparam logic [3:0] SUB_ADD_RT   = 4'd0;
    localparam logic [3:0] SUB_ADD_RM1  = 4'd1;
    localparam logic [3:0] SUB_ADD_RM2  = 4'd2;
    localparam logic [3:0] SUB_INC_C2   = 4'd0;
    localparam logic [3:0] SUB_INC_C3   = 4'd1;
    localparam logic [3:0] SUB_INC_M2   = 4'd2;
    localparam logic [3:0] SUB_INC_K2   = 4'd3;
    localparam logic [3:0] SUB_INC_N2   = 4'd4;

    typedef enum logic [5:0] {
        IDLE = 6'd0,
        FETCH1, FETCH2, FETCH3,
        JMPM, JMPK, JMPN, JMP2, JMP3, JMP4, NJMP,
        COPY1, COPY2, COPY3, COPY4, COPYM, COPYK, COPYN,
        LOADC1, LOADC2, LOAD2, LOAD3,
        STORE1, STORE2, STORE3,
        RSTALL, RSTN2, RSTK2,
        MOVEP, MOVET, MOVEC1,
        SETC1, SETDR,
        MUL1,
        ADDRT, ADDRM1, ADDRM2,
        INCC2, INCC3, INCM2, INCK2, INCN2
    } cuState_e;

    // Datapath bus source select
    typedef enum logic [3:0] {
        BUS_NONE = 4'd0,
        BUS_AC   = 4'd1,
        BUS_C3   = 4'd2,
        BUS_C2   = 4'd3,
        BUS_C1   = 4'd4,
        BUS_RN2  = 4'd5,
        BUS_RK2  = 4'd6,
        BUS_RM2  = 4'd7,
        BUS_RN1  = 4'd8,
        BUS_RK1  = 4'd9,
        BUS_RM1  = 4'd10,
        BUS_RT   = 4'd11,
        BUS_RP   = 4'd12,
        BUS_DR   = 4'd13,
        BUS_AR   = 4'd14
    } busSrc_e;

    typedef enum logic [2:0] {
        ALU_NONE = 3'd0,
        ALU_SET  = 3'd1,
        ALU_MUL  = 3'd2,
        ALU_ADD  = 3'd4
    } aluOp_e;

    // Write-enable bit positions
    typedef enum logic [3:0] {
        REG_AC  = 4'd0,
        REG_C3  = 4'd1,
        REG_C2  = 4'd2,
        REG_C1  = 4'd3,
        REG_RN2 = 4'd4,
        REG_RK2 = 4'd5,
        REG_RM2 = 4'd6,
        REG_RN1 = 4'd7,
        REG_RK1 = 4'd8,
        REG_RM1 = 4'd9,
        REG_RT  = 4'd10,
        REG_RP  = 4'd11,
        REG_DR  = 4'd12,
        REG_AR  = 4'd13,
        REG_IR  = 4'd14,
        REG_PC  = 4'd15
    } regIdx_e;

    localparam int INC_C3  = 0; // Increment vector
    localparam int INC_C2  = 1;
    localparam int INC_RN2 = 2;
    localparam int INC_RK2 = 3;
    localparam int INC_RM2 = 4;
    localparam int INC_PC  = 5;

    localparam int RST_AC  = 0; // Clear vector
    localparam int RST_RN2 = 1;
    localparam int RST_RK2 = 2;
    localparam int RST_RM2 = 3;
    localparam int RST_RT  = 4;

    localparam int CMP_N = 0; // Compare-select vector
    localparam int CMP_K = 1;
    localparam int CMP_M = 2;

    typedef struct packed {
        logic                   iRomRead;
        logic                   memRead;
        logic                   memWrite;
        logic [`CU_REG_N-1:0]   wEn;
        busSrc_e                busSel;
        logic [`CU_INC_W-1:0]   inc;
        logic [`CU_RST_W-1:0]   rst;
        logic [`CU_CMP_W-1:0]   compSel;
        aluOp_e                 aluOp;
    } ctrlWord_t;

    typedef struct packed {
        opcode_e                op;
        logic [`CU_INSTR_W-5:0] sub;
    } instr_t;

endpackage

// ==== instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  cu_pkg::instr_t   latchedInstr,
    output cu_pkg::cuState_e entryState
);

    import cu_pkg::*;

    // First execute state; IDLE covers NOOP and every undefined code
    always_comb begin
        entryState = IDLE;
        case (latchedInstr.op)
            OP_JMP: begin
                case (latchedInstr.sub)
                    SUB_JMP_M: entryState = JMPM;
                    SUB_JMP_K: entryState = JMPK;
                    SUB_JMP_N: entryState = JMPN;
                    default:   entryState = IDLE;
                endcase
            end
            OP_COPY:  entryState = COPY1; // Target picked later in COPY4
            OP_LOAD: begin
                case (latchedInstr.sub)
                    SUB_LOAD_C1: entryState = LOADC1;
                    SUB_LOAD_C2: entryState = LOADC2;
                    default:     entryState = IDLE;
                endcase
            end
            OP_STORE: entryState = STORE1;
            OP_RESET: begin
                case (latchedInstr.sub)
                    SUB_RST_ALL: entryState = RSTALL;
                    SUB_RST_N2:  entryState = RSTN2;
                    SUB_RST_K2:  entryState = RSTK2;
                    default:     entryState = IDLE;
                endcase
            end
            OP_MOVE: begin
                case (latchedInstr.sub)
                    SUB_MOVE_RP: entryState = MOVEP;
                    SUB_MOVE_RT: entryState = MOVET;
                    SUB_MOVE_C1: entryState = MOVEC1;
                    default:     entryState = IDLE;
                endcase
            end
            OP_SET: begin
                case (latchedInstr.sub)
                    SUB_SET_C1: entryState = SETC1;
                    SUB_SET_DR: entryState = SETDR;
                    default:    entryState = IDLE;
                endcase
            end
            OP_MUL:   entryState = MUL1; // AC <= RP * AC
            OP_ADD: begin
                case (latchedInstr.sub)
                    SUB_ADD_RT:  entryState = ADDRT;
                    SUB_ADD_RM1: entryState = ADDRM1;
                    SUB_ADD_RM2: entryState = ADDRM2;
                    default:     entryState = IDLE;
                endcase
            end
            OP_INC: begin
                case (latchedInstr.sub)
                    SUB_INC_C2: entryState = INCC2;
                    SUB_INC_C3: entryState = INCC3;
                    SUB_INC_M2: entryState = INCM2;
                    SUB_INC_K2: entryState = INCK2;
                    SUB_INC_N2: entryState = INCN2;
                    default:    entryState = IDLE;
                endcase
            end
            default:  entryState = IDLE;
        endcase
    end

endmodule

// ==== cuSequencer.sv ====
`timescale 1ns/1ps

module cuSequencer (
    input  logic             Clk,
    input  logic             rstN,
    input  logic             z,
    input  cu_pkg::instr_t   regIr,
    input  cu_pkg::cuState_e entryState,
    output cu_pkg::cuState_e state,
    output cu_pkg::instr_t   latchedInstr
);

    import cu_pkg::*;

    cuState_e nextState;
    instr_t   instrReg;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Latched in FETCH3 and held for the rest of the instruction
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            instrReg <= '0;
        end else if (state == FETCH3) begin
            instrReg <= regIr;
        end
    end

    // Bypass so the decoder sees the new instruction during FETCH3
    assign latchedInstr = (state == FETCH3) ? regIr : instrReg;

    always_comb begin
        nextState = FETCH1; // Default covers every last execute cycle
        case (state)
            IDLE:   nextState = FETCH1;
            FETCH1: nextState = FETCH2;
            FETCH2: nextState = FETCH3;
            FETCH3: nextState = entryState;

            // Compare result sampled in the first jump cycle
            JMPM, JMPK, JMPN: begin
                if (z) begin
                    nextState = NJMP;
                end else begin
                    nextState = JMP2;
                end
            end
            JMP2:   nextState = JMP3;
            JMP3:   nextState = JMP4;

            COPY1:  nextState = COPY2;
            COPY2:  nextState = COPY3;
            COPY3:  nextState = COPY4;
            COPY4: begin
                case (instrReg.sub)
                    SUB_COPY_M1: nextState = COPYM;
                    SUB_COPY_K1: nextState = COPYK;
                    SUB_COPY_N1: nextState = COPYN;
                    default:     nextState = IDLE; // Bad target, drop it
                endcase
            end

            LOADC1, LOADC2: nextState = LOAD2;
            LOAD2:  nextState = LOAD3;

            STORE1: nextState = STORE2;
            STORE2: nextState = STORE3;

            default: nextState = FETCH1;
        endcase
    end

    // Once out of reset the FSM must always hold a known state
    stateKnown: assert property (@(posedge Clk) disable iff (!rstN) !$isunknown(state))
        else $error("cuSequencer state is unknown");

endmodule

// ==== controlWordGen.sv ====
`timescale 1ns/1ps

module controlWordGen (
    input  cu_pkg::cuState_e  state,
    output cu_pkg::ctrlWord_t ctrl
);

    import cu_pkg::*;

    // Moore output table with unnamed fields left at zero
    always_comb begin
        ctrl = '0;
        case (state)
            FETCH1, COPY1, JMP2: ctrl.iRomRead = 1'b1; // Read instruction ROM at PC
            FETCH2: begin
                ctrl.wEn[REG_IR] = 1'b1;
                ctrl.inc[INC_PC] = 1'b1;
            end

            JMPM: ctrl.compSel[CMP_M] = 1'b1; // M1 - M2
            JMPK: ctrl.compSel[CMP_K] = 1'b1; // K1 - K2
            JMPN: ctrl.compSel[CMP_N] = 1'b1; // N1 - N2
            JMP3: ctrl.wEn[REG_AR] = 1'b1;    // AR <= target from ROM
            JMP4: begin
                ctrl.wEn[REG_PC] = 1'b1;
                ctrl.busSel = BUS_AR;
            end
            NJMP: ctrl.inc[INC_PC] = 1'b1;    // Skip the target word

            // Address word from ROM, then operand from memory
            COPY2: begin
                ctrl.wEn[REG_AR] = 1'b1;
                ctrl.inc[INC_PC] = 1'b1;
            end
            COPY3, LOAD2: ctrl.memRead = 1'b1;
            COPY4, LOAD3: ctrl.wEn[REG_DR] = 1'b1;
            COPYM: begin
                ctrl.wEn[REG_RM1] = 1'b1;
                ctrl.busSel = BUS_DR;
            end
            COPYK: begin
                ctrl.wEn[REG_RK1] = 1'b1;
                ctrl.busSel = BUS_DR;
            end
            COPYN: begin
                ctrl.memRead = 1'b1; // Extra read on the N1 copy
                ctrl.wEn[REG_RN1] = 1'b1;
                ctrl.busSel = BUS_DR;
            end

            LOADC1: begin
                ctrl.wEn[REG_AR] = 1'b1;
                ctrl.busSel = BUS_C1;
            end
            LOADC2: begin
                ctrl.wEn[REG_AR] = 1'b1;
                ctrl.busSel = BUS_C2;
            end

            STORE1: begin
                ctrl.wEn[REG_DR] = 1'b1; // DR <= RT
                ctrl.busSel = BUS_RT;
            end
            STORE2: begin
                ctrl.wEn[REG_AR] = 1'b1; // AR <= C3
                ctrl.busSel = BUS_C3;
            end
            STORE3: begin
                ctrl.memWrite = 1'b1;
                ctrl.busSel = BUS_DR;
            end

            RSTALL: begin
                ctrl.rst[RST_RT] = 1'b1;
                ctrl.rst[RST_RM2] = 1'b1;
                ctrl.rst[RST_RK2] = 1'b1;
                ctrl.rst[RST_RN2] = 1'b1;
                ctrl.rst[RST_AC] = 1'b1;
            end
            RSTN2: ctrl.rst[RST_RN2] = 1'b1;
            RSTK2: ctrl.rst[RST_RK2] = 1'b1;

            MOVEP, MOVET, MOVEC1: begin
                ctrl.busSel = BUS_AC;
                if (state == MOVEP) begin
                    ctrl.wEn[REG_RP] = 1'b1;
                end else if (state == MOVET) begin
                    ctrl.wEn[REG_RT] = 1'b1;
                end else begin
                    ctrl.wEn[REG_C1] = 1'b1;
                end
            end

            // Every ALU op lands in AC
            SETC1, SETDR: begin
                ctrl.wEn[REG_AC] = 1'b1;
                ctrl.aluOp = ALU_SET;
                ctrl.busSel = (state == SETC1) ? BUS_C1 : BUS_DR;
            end
            MUL1: begin
                ctrl.wEn[REG_AC] = 1'b1;
                ctrl.aluOp = ALU_MUL;
                ctrl.busSel = BUS_RP;
            end
            ADDRT, ADDRM1, ADDRM2: begin
                ctrl.wEn[REG_AC] = 1'b1;
                ctrl.aluOp = ALU_ADD;
                if (state == ADDRT) begin
                    ctrl.busSel = BUS_RT;
                end else if (state == ADDRM1) begin
                    ctrl.busSel = BUS_RM1;
                end else begin
                    ctrl.busSel = BUS_RM2;
                end
            end

            INCC2: ctrl.inc[INC_C2] = 1'b1;
            INCC3: ctrl.inc[INC_C3] = 1'b1;
            INCM2: ctrl.inc[INC_RM2] = 1'b1;
            INCK2: ctrl.inc[INC_RK2] = 1'b1;
            INCN2: ctrl.inc[INC_RN2] = 1'b1;

            default: ctrl = '0; // IDLE, FETCH3
        endcase
    end

    // Checked on every state change against the word of the state being left
    memPortExcl: assert property (@(state) !(ctrl.memRead && ctrl.memWrite))
        else $error("memRead and memWrite asserted together");

    // Single write port on the bus
    singleWrite: assert property (@(state) $onehot0(ctrl.wEn))
        else $error("More than one register write enable set");

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              z,
    input  cu_pkg::instr_t    regIr,
    output cu_pkg::ctrlWord_t ctrl
);

    import cu_pkg::*;

    cuState_e state;
    cuState_e entryState;
    instr_t   latchedInstr;

    cuSequencer uSequencer (
        .Clk          (Clk),
        .rstN         (rstN),
        .z            (z),
        .regIr        (regIr),
        .entryState   (entryState),
        .state        (state),
        .latchedInstr (latchedInstr)
    );

    instrDecoder uDecoder (
        .latchedInstr (latchedInstr),
        .entryState   (entryState)
    );

    // Control word straight from the state register
    controlWordGen uCtrlGen (
        .state (state),
        .ctrl  (ctrl)
    );

endmodule

// ==== tb_cuTests.svh ====
// Number of legal sub-codes per opcode
function automatic int subCount(input logic [3:0] op);
    case (op)
        4'd1, 4'd2, 4'd6, 4'd7, 4'd10: return 3;
        4'd3, 4'd8: return 2;
        4'd4, 4'd9: return 1;
        4'd11: return 5;
        default: return 0;
    endcase
endfunction

// flags is {iRomRead, memRead, memWrite}
// A negative wIdx means no register write
task automatic addWord(input logic [2:0] flags, input int wIdx, input busSrc_e bus,
                       input logic [5:0] incV, input logic [4:0] rstV,
                       input logic [2:0] cmpV, input aluOp_e alu);
    ctrlWord_t w;
    w = '0;
    {w.iRomRead, w.memRead, w.memWrite} = flags;
    if (wIdx >= 0) begin
        w.wEn[wIdx] = 1'b1;
    end
    w.busSel = bus;
    w.inc = incV;
    w.rst = rstV;
    w.compSel = cmpV;
    w.aluOp = alu;
    expQ.push_back(w);
endtask

task automatic buildExpected(input logic [7:0] code, input logic zVal);
    logic [3:0] op;
    logic [3:0] sub;
    op = code[7:4];
    sub = code[3:0];
    expQ.delete();
    addWord(3'b100, -1, BUS_NONE, 6'h00, 5'h00, 3'h0, ALU_NONE);
    addWord(3'b000, REG_IR, BUS_NONE, 6'h20, 5'h00, 3'h0, ALU_NONE); // IR write and PC bump
    addWord(3'b000, -1, BUS_NONE, 6'h00, 5'h00, 3'h0, ALU_NONE);
    if (sub >= subCount(op)) begin
        addWord(3'b000, -1, BUS_NONE, 6'h00, 5'h00, 3'h0, ALU_NONE); // Single IDLE stall
    end else begin
        case (op)
            4'd1: begin
                addWord(3'b000, -1, BUS_NONE, 6'h00, 5'h00, 3'b100 >> sub, ALU_NONE);
                if (zVal) begin
                    addWord(3'b000, -1, BUS_NONE, 6'h20, 5'h00, 3'h0, ALU_NONE);
                end else begin
                    addWord(3'b100, -1, BUS_NONE, 6'h00, 5'h00, 3'h0, ALU_NONE);
                    addWord(3'b000, REG_AR, BUS_NONE, 6'h00, 5'h00, 3'h0, ALU_NONE);
                    addWord(3'b000, REG_PC, BUS_AR, 6'h00, 5'h00, 3'h0, ALU_NONE);
                end
            end
            4'd2: begin
                addWord(3'b100, -1, BUS_NONE, 6'h00, 5'h00, 3'h0, ALU_NONE);
                addWord(3'b000, REG_AR, BUS_NONE, 6'h20, 5'h00, 3'h0, ALU_NONE);
                addWord(3'b010, -1, BUS_NONE, 6'h00, 5'h00, 3'h0, ALU_NONE);
                addWord(3'b000, REG_DR, BUS_NONE, 6'h00, 5'h00, 3'h0, ALU_NONE);
                // N1 target also raises memRead
                addWord((sub == 2) ? 3'b010 : 3'b000,
                        (sub == 0) ? REG_RM1 : ((sub == 1) ? REG_RK1 : REG_RN1),
                        BUS_DR, 6'h00, 5'h00, 3'h0, ALU_NONE);
            end
            4'd3: begin
                addWord(3'b000, REG_AR, (sub == 0) ? BUS_C1 : BUS_C2,
                        6'h00, 5'h00, 3'h0, ALU_NONE);
                addWord(3'b010, -1, BUS_NONE, 6'h00, 5'h00, 3'h0, ALU_NONE);
                addWord(3'b000, REG_DR, BUS_NONE, 6'h00, 5'h00, 3'h0, ALU_NONE);
            end
            4'd4: begin
                addWord(3'b000, REG_DR, BUS_RT, 6'h00, 5'h00, 3'h0, ALU_NONE);
                addWord(3'b000, REG_AR, BUS_C3, 6'h00, 5'h00, 3'h0, ALU_NONE);
                addWord(3'b001, -1, BUS_DR, 6'h00, 5'h00, 3'h0, ALU_NONE);
            end
            4'd6: addWord(3'b000, -1, BUS_NONE, 6'h00, (sub == 0) ? 5'h1f : (5'h01 << sub),
                          3'h0, ALU_NONE);
            4'd7: addWord(3'b000, (sub == 0) ? REG_RP : ((sub == 1) ? REG_RT : REG_C1),
                          BUS_AC, 6'h00, 5'h00, 3'h0, ALU_NONE);
            4'd8: addWord(3'b000, REG_AC, (sub == 0) ? BUS_C1 : BUS_DR,
                          6'h00, 5'h00, 3'h0, ALU_SET);
            4'd9: addWord(3'b000, REG_AC, BUS_RP, 6'h00, 5'h00, 3'h0, ALU_MUL);
            4'd10: addWord(3'b000, REG_AC, (sub == 0) ? BUS_RT : ((sub == 1) ? BUS_RM1 : BUS_RM2),
                           6'h00, 5'h00, 3'h0, ALU_ADD);
            // C2 bit 1, C3 bit 0, then M2, K2, N2 from bit 4 down
            4'd11: addWord(3'b000, -1, BUS_NONE, 6'h01 << ((sub < 2) ? 1 - sub : 6 - sub),
                           5'h00, 3'h0, ALU_NONE);
            default: ;
        endcase
    end
endtask

task automatic playInstr(input logic [7:0] code, input logic zVal);
    string tag;
    int    i;
    int    waitCnt;
    tag = $sformatf("instr %h z %b", code, zVal);
    buildExpected(code, zVal);
    waitCnt = 0;
    while (ctrl.iRomRead !== 1'b1 && waitCnt < 16) begin
        nextCycle();
        waitCnt++;
    end
    if (ctrl.iRomRead !== 1'b1) begin
        $display("No instruction fetch seen before %s", tag);
        errCount++;
    end
    for (i = 0; i < expQ.size(); i++) begin
        if (i == 2) begin
            regIr = instr_t'(code); // IR holds the new word from FETCH3 on
        end
        // Compare result is only valid in the cycle that selects a pair
        z = (expQ[i].compSel != 3'h0) ? zVal : ~zVal;
        compareCtrl(expQ[i], tag);
        nextCycle();
    end
    compareCtrl(expQ[0], {tag, " refetch"});
endtask

task automatic resetSequence();
    int errBefore;
    errBefore = errCount;
    repeat (8) begin
        nextCycle();
        compareCtrl('0, "during reset");
    end
    rstN = 1'b1;
    compareCtrl('0, "first cycle after reset");
    nextCycle();
    if (ctrl.iRomRead !== 1'b1) begin
        $display("CHECK FAILED at %0t ns: ctrl.iRomRead expected 1, got %b",
                 $time, ctrl.iRomRead);
        errCount++;
    end
    reportTest("reset", errBefore);
endtask

// Every legal sub-code of each opcode in the range with z at 0 and 1
task automatic groupSweep(input logic [3:0] opLo, input logic [3:0] opHi, input string name);
    int errBefore;
    int op;
    int sub;
    int zv;
    errBefore = errCount;
    for (op = opLo; op <= opHi; op++) begin
        for (sub = 0; sub < subCount(op[3:0]); sub++) begin
            for (zv = 0; zv < 2; zv++) begin
                playInstr({op[3:0], sub[3:0]}, zv[0]);
            end
        end
    end
    reportTest(name, errBefore);
endtask

task automatic undefinedCodes();
    int errBefore;
    errBefore = errCount;
    playInstr(8'h50, 1'b0); // Opcode 5 is unused
    playInstr(8'h73, 1'b0); // MOVE has no sub-code 3
    reportTest("undefined codes", errBefore);
endtask

task automatic randomProgram(input int count);
    int          errBefore;
    logic [31:0] r;
    int          opIdx;
    int          op;
    int          sub;
    errBefore = errCount;
    repeat (count) begin
        r = lcgNext();
        opIdx = (r >> 16) % 10;
        op = (opIdx < 4) ? opIdx + 1 : opIdx + 2; // Skip unused opcode 5
        sub = (r >> 24) % subCount(op[3:0]);
        playInstr({op[3:0], sub[3:0]}, r[12]);
    end
    reportTest("random program", errBefore);
endtask

// ==== tb_controlUnit.sv ====
`timescale 1ns/1ps

module tb_controlUnit;

    import cu_pkg::*;

    // About 600 cycles of tests plus a wide margin
    localparam int MAX_CYCLES = 2000;

    logic      Clk;
    logic      rstN;
    logic      z;
    instr_t    regIr;
    ctrlWord_t ctrl;

    ctrlWord_t   expQ[$];          // Expected words of the current instruction
    logic [31:0] lcgState;
    int          cycleCnt = 0;
    int          errCount = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    controlUnit DUT (
        .Clk   (Clk),
        .rstN  (rstN),
        .z     (z),
        .regIr (regIr),
        .ctrl  (ctrl)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    always @(posedge Clk) cycleCnt <= cycleCnt + 1;

    initial begin
        wait (cycleCnt >= MAX_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Inputs move and outputs are sampled 1 ns after the edge
    task automatic nextCycle();
        @(posedge Clk);
        #1;
    endtask

    task automatic compareCtrl(input ctrlWord_t expWord, input string tag);
        if (ctrl !== expWord) begin
            $display("CHECK FAILED at %0t ns: ctrl expected %h, got %h (%s)",
                     $time, expWord, ctrl, tag);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testsRun++;
        if (errCount == errBefore) begin
            $display("%0t ns  %s: ok", $time, name);
        end else begin
            testsFailed++;
            $display("%0t ns  %s: %0d errors", $time, name, errCount - errBefore);
        end
    endtask

    `include "tb_cuTests.svh"

    initial begin
        rstN = 1'b0;
        z = 1'b0;
        regIr = '0;
        lcgState = 32'h6e98;
        resetSequence();
        groupSweep(4'd6, 4'd11, "single-cycle groups");
        groupSweep(4'd1, 4'd1, "jumps");
        groupSweep(4'd2, 4'd4, "copy, load and store");
        undefinedCodes();
        randomProgram(40);
        $display("Tests: %0d run, %0d failed, %0d check errors",
                 testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
cu_pkg.sv
instrDecoder.sv
cuSequencer.sv
controlWordGen.sv
controlUnit.sv
tb_controlUnit.sv

// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - include_dirs:
      - .
    files:
      - cu_pkg.sv
      - instrDecoder.sv
      - cuSequencer.sv
      - controlWordGen.sv
      - controlUnit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_controlUnit.sv
